// File: logic/icache_config.svh
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// cpu word width in bits
`define ICACHE_WORD_SIZE 16

// line geometry
`define ICACHE_LINE_WORDS 4
`define ICACHE_OFFSET_BITS 2

// set geometry
`define ICACHE_SETS 2
`define ICACHE_INDEX_BITS 1

// whatever is left of the word after index and offset
`define ICACHE_TAG_BITS (`ICACHE_WORD_SIZE - `ICACHE_INDEX_BITS - `ICACHE_OFFSET_BITS)

// width of each statistics counter
`define ICACHE_COUNT_WIDTH 16

`endif

// File: logic/icache_pkg.sv
`include "icache_config.svh"

package icache_pkg;

    // associativity is fixed by the one-bit way fields below
    localparam int unsigned ICACHE_WAYS = 2;

    // cpu word address split for lookup
    typedef struct packed {
        logic [`ICACHE_TAG_BITS-1:0]   tag;
        logic [`ICACHE_INDEX_BITS-1:0] index;
        logic [`ICACHE_OFFSET_BITS-1:0] offset;
    } icache_addr_fields_t;

    // same word seen either raw or as fields
    typedef union packed {
        logic [`ICACHE_WORD_SIZE-1:0] raw;
        icache_addr_fields_t          fields;
    } icache_addr_u;

    // word k of a line sits at element k
    typedef logic [`ICACHE_LINE_WORDS-1:0][`ICACHE_WORD_SIZE-1:0] icache_line_t;

    // one tag entry as read out of the tag store
    typedef struct packed {
        logic                        valid;
        logic                        recent;
        logic [`ICACHE_TAG_BITS-1:0] tag;
    } icache_tag_entry_t;

    // tag store result for the current address
    typedef struct packed {
        logic hit;
        logic hit_way;
        logic victim_way;
    } icache_lookup_t;

    // tag store write request from control
    typedef struct packed {
        logic touch;
        logic fill;
        logic way;
    } icache_tag_update_t;

    // completed cpu request
    typedef struct packed {
        logic ready;
        logic was_hit;
    } icache_resp_t;

endpackage

// File: logic/icache_tag_store.sv
`timescale 1ns/1ps

`include "icache_config.svh"

module icache_tag_store import icache_pkg::*; (
    input  logic               clk,
    input  logic               reset_n,
    input  icache_addr_u       cpu_address,
    input  icache_tag_update_t tag_update,
    output icache_lookup_t     lookup
);

    logic [ICACHE_WAYS-1:0]      valid_q  [`ICACHE_SETS];
    logic [ICACHE_WAYS-1:0]      recent_q [`ICACHE_SETS];
    logic [`ICACHE_TAG_BITS-1:0] tag_q    [`ICACHE_SETS][ICACHE_WAYS];

    logic [`ICACHE_INDEX_BITS-1:0] set_idx;
    icache_tag_entry_t             entry [ICACHE_WAYS];
    logic [ICACHE_WAYS-1:0]        way_match;

    assign set_idx = cpu_address.fields.index;

    // combinational read of both ways at the request index
    always_comb begin
        for (int w = 0; w < ICACHE_WAYS; w++) begin
            entry[w].valid = valid_q[set_idx][w];
            entry[w].recent = recent_q[set_idx][w];
            entry[w].tag = tag_q[set_idx][w];
            way_match[w] = entry[w].valid && (entry[w].tag == cpu_address.fields.tag);
        end
    end

    assign lookup.hit = |way_match;
    // way 0 wins if it matches, otherwise way 1
    assign lookup.hit_way = ~way_match[0];
    // replace way 0 unless it was the last one used
    assign lookup.victim_way = entry[0].recent;

    // valid and recent state
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                valid_q[s] <= '0;
                recent_q[s] <= '0;
            end
        end else if (tag_update.touch || tag_update.fill) begin
            recent_q[set_idx][tag_update.way] <= 1'b1;
            recent_q[set_idx][~tag_update.way] <= 1'b0;
            if (tag_update.fill) begin
                valid_q[set_idx][tag_update.way] <= 1'b1;
            end
        end
    end

    // tags only change on refill
    always_ff @(posedge clk) begin
        if (tag_update.fill) begin
            tag_q[set_idx][tag_update.way] <= cpu_address.fields.tag;
        end
    end

endmodule

// File: logic/icache_data_store.sv
`timescale 1ns/1ps

`include "icache_config.svh"

module icache_data_store import icache_pkg::*; (
    input  logic                         clk,
    input  icache_addr_u                 cpu_address,
    input  icache_lookup_t               lookup,
    input  logic                         fill_we,
    input  logic                         fill_way,
    input  icache_line_t                 mem_line,
    output logic [`ICACHE_WORD_SIZE-1:0] cpu_data
);

    icache_line_t lines_q [`ICACHE_SETS][ICACHE_WAYS];

    logic [`ICACHE_INDEX_BITS-1:0]  set_idx;
    logic [`ICACHE_OFFSET_BITS-1:0] word_idx;
    icache_line_t                   line_sel;

    assign set_idx = cpu_address.fields.index;
    assign word_idx = cpu_address.fields.offset;

    // refill writes the whole line into the victim way
    always_ff @(posedge clk) begin
        if (fill_we) begin
            lines_q[set_idx][fill_way] <= mem_line;
        end
    end

    // during refill the stored line is stale, so take the incoming one
    always_comb begin
        if (fill_we) begin
            line_sel = mem_line;
        end else begin
            line_sel = lines_q[set_idx][lookup.hit_way];
        end
    end

    assign cpu_data = line_sel[word_idx];

endmodule

// File: logic/icache_stats.sv
`timescale 1ns/1ps

`include "icache_config.svh"

module icache_stats import icache_pkg::*; (
    input  logic                           clk,
    input  logic                           reset_n,
    input  icache_resp_t                   resp,
    output logic [`ICACHE_COUNT_WIDTH-1:0] access_count,
    output logic [`ICACHE_COUNT_WIDTH-1:0] hit_count
);

    logic access_full;
    logic hit_full;

    // counters stick at all ones
    assign access_full = &access_count;
    assign hit_full = &hit_count;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            access_count <= '0;
            hit_count <= '0;
        end else if (resp.ready) begin
            if (!access_full) begin
                access_count <= access_count + 1'b1;
            end
            if (resp.was_hit && !hit_full) begin
                hit_count <= hit_count + 1'b1;
            end
        end
    end

endmodule

// File: logic/icache_ctrl.sv
`timescale 1ns/1ps

`include "icache_config.svh"

module icache_ctrl import icache_pkg::*; (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         cpu_valid,
    input  icache_lookup_t               lookup,
    input  icache_addr_u                 cpu_address,
    input  logic                         mem_ready,
    output logic                         mem_read,
    output logic [`ICACHE_WORD_SIZE-1:0] mem_address,
    output icache_tag_update_t           tag_update,
    output logic                         fill_we,
    output logic                         fill_way,
    output icache_resp_t                 resp
);

    typedef enum logic {
        CHECK    = 1'b0,
        ALLOCATE = 1'b1
    } state_e;

    state_e state_q;
    state_e state_d;

    // way picked for the refill, held for the whole miss
    logic victim_q;

    // line-aligned copy of the request address
    icache_addr_u line_address;

    always_comb begin
        line_address = cpu_address;
        line_address.fields.offset = '0;
    end

    assign mem_address = line_address.raw;

    always_comb begin
        state_d = state_q;

        mem_read = 1'b0;
        fill_we = 1'b0;
        fill_way = victim_q;

        tag_update.touch = 1'b0;
        tag_update.fill = 1'b0;
        tag_update.way = lookup.hit_way;

        resp.ready = 1'b0;
        resp.was_hit = 1'b0;

        case (state_q)
            CHECK: begin
                if (cpu_valid) begin
                    if (lookup.hit) begin
                        // zero-cycle hit, recent bits move at the edge
                        resp.ready = 1'b1;
                        resp.was_hit = 1'b1;
                        tag_update.touch = 1'b1;
                    end else begin
                        // request goes out in the same cycle the miss is seen
                        mem_read = 1'b1;
                        state_d = ALLOCATE;
                    end
                end
            end

            ALLOCATE: begin
                mem_read = 1'b1;
                tag_update.way = victim_q;
                if (mem_ready) begin
                    // line and tag land at this edge, word goes out by bypass
                    fill_we = 1'b1;
                    tag_update.fill = 1'b1;
                    resp.ready = 1'b1;
                    state_d = CHECK;
                end
            end

            default: begin
                state_d = CHECK;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state_q <= CHECK;
        end else begin
            state_q <= state_d;
        end
    end

    // capture the victim when leaving CHECK on a miss
    always_ff @(posedge clk) begin
        if (state_q == CHECK && state_d == ALLOCATE) begin
            victim_q <= lookup.victim_way;
        end
    end

endmodule

// File: logic/icache.sv
`timescale 1ns/1ps

`include "icache_config.svh"

module icache import icache_pkg::*; (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           cpu_valid,
    input  logic [`ICACHE_WORD_SIZE-1:0]   cpu_address,
    output logic [`ICACHE_WORD_SIZE-1:0]   cpu_data,
    output logic                           cpu_ready,
    output logic                           mem_read,
    output logic [`ICACHE_WORD_SIZE-1:0]   mem_address,
    input  icache_line_t                   mem_line,
    input  logic                           mem_ready,
    output logic [`ICACHE_COUNT_WIDTH-1:0] access_count,
    output logic [`ICACHE_COUNT_WIDTH-1:0] hit_count
);

    icache_addr_u       addr;
    icache_lookup_t     lookup;
    icache_tag_update_t tag_update;
    icache_resp_t       resp;
    logic               fill_we;
    logic               fill_way;

    assign addr = icache_addr_u'(cpu_address);
    assign cpu_ready = resp.ready;

    icache_ctrl i_ctrl (
        .clk         (clk),
        .reset_n     (reset_n),
        .cpu_valid   (cpu_valid),
        .lookup      (lookup),
        .cpu_address (addr),
        .mem_ready   (mem_ready),
        .mem_read    (mem_read),
        .mem_address (mem_address),
        .tag_update  (tag_update),
        .fill_we     (fill_we),
        .fill_way    (fill_way),
        .resp        (resp)
    );

    icache_tag_store i_tag_store (
        .clk         (clk),
        .reset_n     (reset_n),
        .cpu_address (addr),
        .tag_update  (tag_update),
        .lookup      (lookup)
    );

    icache_data_store i_data_store (
        .clk         (clk),
        .cpu_address (addr),
        .lookup      (lookup),
        .fill_we     (fill_we),
        .fill_way    (fill_way),
        .mem_line    (mem_line),
        .cpu_data    (cpu_data)
    );

    icache_stats i_stats (
        .clk          (clk),
        .reset_n      (reset_n),
        .resp         (resp),
        .access_count (access_count),
        .hit_count    (hit_count)
    );

endmodule

// File: tests/icache_properties.sv
`timescale 1ns/1ps

`include "icache_config.svh"

module icache_properties (
    input logic                         clk,
    input logic                         reset_n,
    input logic                         cpu_valid,
    input logic                         cpu_ready,
    input logic                         mem_read,
    input logic [`ICACHE_WORD_SIZE-1:0] mem_address,
    input logic                         mem_ready
);

    // number of failed assertions, read back by the testbench
    int unsigned failures = 0;

    // a response only answers a live request
    ready_needs_valid: assert property (
        @(posedge clk) disable iff (!reset_n) cpu_ready |-> cpu_valid
    ) else begin
        failures++;
        $error("cpu_ready high without cpu_valid");
    end

    // refill request held steady until the memory answers
    read_held: assert property (
        @(posedge clk) disable iff (!reset_n)
        (mem_read && !mem_ready) |=> (mem_read && $stable(mem_address))
    ) else begin
        failures++;
        $error("mem_read dropped or mem_address moved before mem_ready");
    end

    // refills are always whole lines
    read_aligned: assert property (
        @(posedge clk) disable iff (!reset_n)
        mem_read |-> (mem_address[`ICACHE_OFFSET_BITS-1:0] == '0)
    ) else begin
        failures++;
        $error("mem_address is not line aligned");
    end

    // outputs quiet while held in reset
    quiet_in_reset: assert property (
        @(posedge clk) !reset_n |-> (!cpu_ready && !mem_read)
    ) else begin
        failures++;
        $error("cpu_ready or mem_read high during reset");
    end

endmodule

bind icache icache_properties i_properties (.*);

// File: tests/icache_tb.sv
`timescale 1ns/1ps

`include "icache_config.svh"

module icache_tb import icache_pkg::*; ();

    localparam time CLK_PERIOD = 10;
    localparam time SAMPLE_DELAY = 2;
    localparam int RESET_CYCLES = 5;

    // request counts per sequence
    localparam int COLD_REQS = 2;
    localparam int HIT_REQS = 4;
    localparam int ASSOC_REQS = 5;
    localparam int LRU_REQS = 3;
    localparam int RANDOM_REQS = 40;
    localparam int RESET_REQS = 2;
    localparam int TOTAL_REQS =
        COLD_REQS + HIT_REQS + ASSOC_REQS + LRU_REQS + RANDOM_REQS + RESET_REQS;
    localparam time TIMEOUT = (TOTAL_REQS * 10 + 2 * RESET_CYCLES) * CLK_PERIOD;

    logic                           clk;
    logic                           reset_n;
    logic                           cpu_valid;
    logic [`ICACHE_WORD_SIZE-1:0]   cpu_address;
    logic [`ICACHE_WORD_SIZE-1:0]   cpu_data;
    logic                           cpu_ready;
    logic                           mem_read;
    logic [`ICACHE_WORD_SIZE-1:0]   mem_address;
    icache_line_t                   mem_line;
    logic                           mem_ready;
    logic [`ICACHE_COUNT_WIDTH-1:0] access_count;
    logic [`ICACHE_COUNT_WIDTH-1:0] hit_count;

    integer seed = 32'hc3a8_6dc0;
    int errors;
    int i;
    logic [31:0] rnd;

    // reference tag state, same shape as the cache
    logic                        model_valid  [`ICACHE_SETS][ICACHE_WAYS];
    logic                        model_recent [`ICACHE_SETS][ICACHE_WAYS];
    logic [`ICACHE_TAG_BITS-1:0] model_tag    [`ICACHE_SETS][ICACHE_WAYS];
    int                          model_accesses;
    int                          model_hits;

    icache i_icache (
        .clk          (clk),
        .reset_n      (reset_n),
        .cpu_valid    (cpu_valid),
        .cpu_address  (cpu_address),
        .cpu_data     (cpu_data),
        .cpu_ready    (cpu_ready),
        .mem_read     (mem_read),
        .mem_address  (mem_address),
        .mem_line     (mem_line),
        .mem_ready    (mem_ready),
        .access_count (access_count),
        .hit_count    (hit_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        assert (got === expected) else begin
            $display("Mismatch %s: got 0x%0h expected 0x%0h at %0t",
                     name, got, expected, $time);
            errors++;
        end
    endtask

    // memory contents follow the address xor rule
    function automatic icache_line_t line_from_memory(input logic [`ICACHE_WORD_SIZE-1:0] base);
        icache_line_t line;
        for (int k = 0; k < `ICACHE_LINE_WORDS; k++) begin
            line[k] = (base + `ICACHE_WORD_SIZE'(k)) ^ 16'h5a5a;
        end
        return line;
    endfunction

    task automatic clear_model();
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            for (int w = 0; w < ICACHE_WAYS; w++) begin
                model_valid[s][w] = 1'b0;
                model_recent[s][w] = 1'b0;
                model_tag[s][w] = '0;
            end
        end
        model_accesses = 0;
        model_hits = 0;
    endtask

    // called on a falling edge or at time zero
    task automatic apply_reset();
        reset_n = 1'b0;
        cpu_valid = 1'b0;
        mem_ready = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        clear_model();
    endtask

    task automatic check_counters();
        expect_equal("access_count", access_count, model_accesses);
        expect_equal("hit_count", hit_count, model_hits);
    endtask

    // one cpu request, with the memory answering any refill
    task automatic access(input logic [`ICACHE_WORD_SIZE-1:0] addr);
        icache_addr_u                 a;
        logic [`ICACHE_WORD_SIZE-1:0] line_base;
        logic                         exp_hit;
        logic                         way;
        int                           delay;
        a.raw = addr;
        // first word of the line holding addr
        line_base = addr & ~(`ICACHE_WORD_SIZE'(`ICACHE_LINE_WORDS - 1));
        exp_hit = 1'b0;
        // victim is way 0 unless way 0 was used last
        way = model_recent[a.fields.index][0];
        for (int w = 0; w < ICACHE_WAYS; w++) begin
            if (!exp_hit && model_valid[a.fields.index][w]
                && model_tag[a.fields.index][w] == a.fields.tag) begin
                exp_hit = 1'b1;
                way = w[0];
            end
        end

        @(negedge clk);
        cpu_valid = 1'b1;
        cpu_address = addr;
        #(SAMPLE_DELAY);
        if (exp_hit) begin
            expect_equal("cpu_ready", cpu_ready, 1);
            expect_equal("mem_read", mem_read, 0);
        end else begin
            expect_equal("cpu_ready", cpu_ready, 0);
            expect_equal("mem_read", mem_read, 1);
            expect_equal("mem_address", mem_address, line_base);
            delay = 1 + ($unsigned($random(seed)) % 4);
            // memory stalls before answering
            repeat (delay - 1) begin
                @(negedge clk);
                #(SAMPLE_DELAY);
                expect_equal("mem_read", mem_read, 1);
                expect_equal("cpu_ready", cpu_ready, 0);
            end
            @(negedge clk);
            mem_ready = 1'b1;
            mem_line = line_from_memory(line_base);
            #(SAMPLE_DELAY);
            expect_equal("cpu_ready", cpu_ready, 1);
        end
        expect_equal("cpu_data", cpu_data, addr ^ 16'h5a5a);

        model_recent[a.fields.index][way] = 1'b1;
        model_recent[a.fields.index][way ^ 1'b1] = 1'b0;
        if (!exp_hit) begin
            model_valid[a.fields.index][way] = 1'b1;
            model_tag[a.fields.index][way] = a.fields.tag;
        end
        model_accesses++;
        if (exp_hit) begin
            model_hits++;
        end

        @(negedge clk);
        cpu_valid = 1'b0;
        mem_ready = 1'b0;
        mem_line = '0;
    endtask

    initial begin
        reset_n = 1'b0;
        cpu_valid = 1'b0;
        cpu_address = '0;
        mem_line = '0;
        mem_ready = 1'b0;
        errors = 0;
        apply_reset();
        check_counters();

        // cold misses in both sets
        access(16'h0040);
        access(16'h0046);

        // every word of the first line
        for (i = 0; i < HIT_REQS; i++) begin
            access(16'h0040 + 16'(i));
        end

        // second tag in set 0, then both lines alternate
        access(16'h0081);
        access(16'h0042);
        access(16'h0083);
        access(16'h0041);
        access(16'h0080);

        // third tag evicts the older line
        access(16'h00c0);
        access(16'h0082);
        access(16'h0040);

        // random mix over eight lines
        for (i = 0; i < RANDOM_REQS; i++) begin
            rnd = $random(seed);
            access({11'h000, rnd[4:0]});
        end
        check_counters();

        // reset mid-run forgets the cached lines
        apply_reset();
        check_counters();
        access(16'h0040);
        access(16'h0041);
        check_counters();

        $display("errors: %0d checks, %0d protocol", errors, i_icache.i_properties.failures);
        if (errors == 0 && i_icache.i_properties.failures == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // generous bound of ten cycles per request
    initial begin
        #(TIMEOUT);
        $display("timeout: requests did not complete within %0t", TIMEOUT);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: icache.f
+incdir+logic
logic/icache_pkg.sv
logic/icache_tag_store.sv
logic/icache_data_store.sv
logic/icache_stats.sv
logic/icache_ctrl.sv
logic/icache.sv
tests/icache_properties.sv
tests/icache_tb.sv

// File: Bender.yml
package:
  name: icache

export_include_dirs:
  - logic

sources:
  - files:
      - logic/icache_pkg.sv
      - logic/icache_tag_store.sv
      - logic/icache_data_store.sv
      - logic/icache_stats.sv
      - logic/icache_ctrl.sv
      - logic/icache.sv
  - target: test
    files:
      - tests/icache_properties.sv
      - tests/icache_tb.sv
